// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_waveform
FILELIST := build.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || { echo "simulation failed"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: build.f
rtl/wave_pkg.sv
rtl/bus_pkg.sv
rtl/waveform_sequencer.sv
rtl/bus_decoder.sv
rtl/sample_ram.sv
rtl/dac_spi_port.sv
rtl/waveform_top.sv
tests/tb_waveform.sv

// File: rtl/bus_decoder.sv
// two slaves by adr[31:28]; any other region gets a zero read and an ack one cycle later
`timescale 1ns/1ps

module bus_decoder (
	input logic clk,
	input logic rst_n,

	// master side
	input logic cyc,
	input logic stb,
	input bus_pkg::adr_t adr,
	output bus_pkg::dat_t dat_r,
	output logic ack,

	// ram slave
	output logic ram_cyc,
	input logic ram_ack,
	input bus_pkg::dat_t ram_dat_r,

	// spi slave
	output logic spi_cyc,
	input logic spi_ack,
	input bus_pkg::dat_t spi_dat_r
);

	logic [3:0] region;
	logic active; // cycle open with strobe
	logic sel_ram;
	logic sel_spi;
	logic unm_ack; // responder for unmapped regions

	assign region = adr[31:28];
	assign active = cyc & stb;
	assign sel_ram = (region == bus_pkg::region_ram);
	assign sel_spi = (region == bus_pkg::region_spi);

	assign ram_cyc = active & sel_ram; // only the addressed slave sees cyc
	assign spi_cyc = active & sel_spi;

	// single pulse so the master never hangs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			unm_ack <= 1'b0;
		end else begin
			unm_ack <= active & ~sel_ram & ~sel_spi & ~unm_ack;
		end
	end

	// response mux
	always_comb begin
		if (sel_ram) begin
			ack = ram_ack;
			dat_r = ram_dat_r;
		end else if (sel_spi) begin
			ack = spi_ack;
			dat_r = spi_dat_r;
		end else begin
			ack = unm_ack;
			dat_r = '0; // unmapped reads as zero
		end
	end

endmodule

// File: rtl/bus_pkg.sv
// 32 bit single master bus with full word writes only; region select sits in adr[31:28]
package bus_pkg;

	typedef logic [31:0] adr_t;
	typedef logic [31:0] dat_t;

	// region select values found in adr[31:28]
	localparam logic [3:0] region_ram = 4'd0;
	localparam logic [3:0] region_spi = 4'd1;

	localparam adr_t ram_base = 32'h0000_0000;
	localparam adr_t spi_base = 32'h1000_0000;

	// sample memory, word addressed
	localparam int ram_depth = 1024;
	localparam int ram_adr_w = 10;
	typedef logic [ram_adr_w-1:0] ram_adr_t;

	// spi port register byte offsets from spi_base
	localparam logic [4:0] reg_arm = 5'd4; // bit 0 arms the shifter
	localparam logic [4:0] reg_data = 5'd12; // frame to send
	localparam logic [4:0] reg_fin = 5'd16; // blocks until the shifter is idle

endpackage

// File: rtl/dac_spi_port.sv
// spi mode 0, msb first, fixed 24 bit frames; arming during a frame is ignored and disarm never cuts one
`timescale 1ns/1ps

module dac_spi_port (
	input logic clk,
	input logic rst_n,

	// bus slave
	input logic cyc,
	input logic we,
	input logic [4:0] reg_sel,
	input bus_pkg::dat_t dat_w,
	output bus_pkg::dat_t dat_r,
	output logic ack,

	// dac pins
	output logic sck,
	output logic mosi,
	output logic cs_n
);

	wave_pkg::frame_t frame; // last written data register
	wave_pkg::frame_t shreg; // shift register, msb on mosi
	logic arm_q; // armed flag for readback
	logic busy; // frame in flight
	logic tail; // last bit done, cs_n rises next
	logic [wave_pkg::div_w-1:0] div; // sck half period divider
	logic [wave_pkg::bit_cnt_w-1:0] bit_cnt;
	logic access; // first cycle of a bus access
	logic wr; // write strobe
	logic fin_rd; // read of the blocking register
	logic arm_go; // arm write of 1

	assign access = cyc & ~ack;
	assign wr = access & we;
	assign fin_rd = ~we & (reg_sel == bus_pkg::reg_fin);
	assign arm_go = wr & (reg_sel == bus_pkg::reg_arm) & dat_w[0];
	assign mosi = shreg[wave_pkg::frame_w-1];

	// fin read stalls while busy, everything else acks next cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack <= 1'b0;
			arm_q <= 1'b0;
		end else begin
			ack <= access & (~fin_rd | ~busy);
			if (wr && reg_sel == bus_pkg::reg_arm) begin
				arm_q <= dat_w[0] & ~busy; // arm while busy does not stick
			end
		end
	end

	// data register and read data
	always_ff @(posedge clk) begin
		if (wr && reg_sel == bus_pkg::reg_data) begin
			frame <= wave_pkg::frame_t'(dat_w);
		end
		if (access && !we) begin
			case (reg_sel)
			bus_pkg::reg_fin: dat_r <= bus_pkg::dat_t'(1); // only seen once idle
			bus_pkg::reg_arm: dat_r <= bus_pkg::dat_t'(arm_q);
			bus_pkg::reg_data: dat_r <= bus_pkg::dat_t'(frame);
			default: dat_r <= '0;
			endcase
		end
	end

	// shifter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			tail <= 1'b0;
			cs_n <= 1'b1;
			sck <= 1'b0;
			div <= '0;
			bit_cnt <= '0;
			shreg <= '0;
		end else if (!busy) begin
			if (arm_go) begin // start only from idle
				busy <= 1'b1;
				cs_n <= 1'b0;
				shreg <= frame; // first bit out with cs_n fall
				bit_cnt <= '0;
				div <= '0;
				sck <= 1'b0;
			end
		end else if (tail) begin
			tail <= 1'b0;
			busy <= 1'b0;
			cs_n <= 1'b1;
		end else if (div != wave_pkg::div_w'(wave_pkg::sck_half - 1)) begin
			div <= div + 1'b1;
		end else begin
			div <= '0;
			sck <= ~sck;
			if (sck) begin // falling edge closes the bit
				if (bit_cnt == wave_pkg::bit_cnt_w'(wave_pkg::frame_w - 1)) begin
					tail <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					shreg <= shreg << 1; // next bit ahead of the rise
				end
			end
		end
	end

endmodule

// File: rtl/sample_ram.sv
// single clock memory of ram_depth words; a host load wins over a bus write in the same cycle
`timescale 1ns/1ps

module sample_ram (
	input logic clk,
	input logic rst_n,

	// bus slave
	input logic cyc,
	input logic we,
	input bus_pkg::ram_adr_t adr,
	input bus_pkg::dat_t dat_w,
	output bus_pkg::dat_t dat_r,
	output logic ack,

	// host load port
	input logic load_we,
	input bus_pkg::ram_adr_t load_adr,
	input wave_pkg::sample_t load_dat
);

	bus_pkg::dat_t mem [bus_pkg::ram_depth];
	logic access; // first cycle of a bus access

	assign access = cyc & ~ack;

	// one ack per cycle, one clock after cyc
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (load_we) begin
			mem[load_adr] <= bus_pkg::dat_t'(load_dat); // zero extended sample
		end else if (access && we) begin
			mem[adr] <= dat_w;
		end
		if (access) begin
			dat_r <= mem[adr]; // valid together with ack
		end
	end

endmodule

// File: rtl/wave_pkg.sv
// playback sizes and the dac frame layout are fixed here; one dac command only, no readback
package wave_pkg;

	localparam int cnt_w = 16; // sample counter and wform_size
	typedef logic [cnt_w-1:0] cnt_t;

	localparam int timer_w = 16; // spacing timer between samples
	typedef logic [timer_w-1:0] timer_t;

	localparam int sample_w = 20; // dac code width
	typedef logic [sample_w-1:0] sample_t;

	localparam int frame_w = 24; // bits shifted out per dac write
	typedef logic [frame_w-1:0] frame_t;

	localparam int dac_write_cmd = 20; // write command bit in every frame
	localparam int sck_half = 2; // clk cycles per sck half period
	localparam int bit_cnt_w = $clog2(frame_w);
	localparam int div_w = $clog2(sck_half) + 1;

	// sequencer states, one bus cycle takes an issue and a wait state
	typedef enum logic [3:0] {
		check_start, check_len, wait_finished,
		read_ram, wait_ram,
		write_data, wait_data,
		write_arm, wait_arm,
		write_disarm, wait_disarm,
		read_fin, wait_fin,
		wait_period
	} seq_state_t;

endpackage

// File: rtl/waveform_sequencer.sv
// single bus master; waits forever on a missing ack and assumes one sample per word at ram_base
`timescale 1ns/1ps

module waveform_sequencer (
	input logic clk,
	input logic rst_n,

	// playback control
	input logic run,
	input logic force_stop,
	input logic do_loop,
	input wave_pkg::cnt_t wform_size,
	input wave_pkg::timer_t timer_spacing,
	output wave_pkg::cnt_t cntr,
	output wave_pkg::timer_t timer,
	output logic ready,
	output logic finished,

	// bus master
	output logic cyc,
	output logic stb,
	output logic we,
	output bus_pkg::adr_t adr,
	output bus_pkg::dat_t dat_w,
	input bus_pkg::dat_t dat_r,
	input logic ack
);

	wave_pkg::seq_state_t state;

	assign stb = cyc; // outputs stable for the whole cycle

	// control path
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= wave_pkg::check_start;
			cntr <= '0;
			timer <= '0;
			ready <= 1'b0;
			finished <= 1'b0;
			cyc <= 1'b0;
			we <= 1'b0;
		end else if (force_stop) begin
			state <= wave_pkg::check_start; // abandon any open cycle
			cyc <= 1'b0;
		end else begin
			case (state)
			wave_pkg::check_start: begin
				if (run) begin
					cntr <= '0;
					ready <= 1'b0;
					state <= wave_pkg::check_len;
				end else begin
					ready <= 1'b1; // host may load now
					finished <= 1'b0;
				end
			end
			wave_pkg::check_len: begin
				if (cntr >= wform_size) begin
					if (do_loop) begin
						cntr <= '0; // wrap and replay
						state <= wave_pkg::read_ram;
					end else begin
						state <= wave_pkg::wait_finished;
					end
				end else begin
					state <= wave_pkg::read_ram;
				end
			end
			wave_pkg::wait_finished: begin
				if (!run) begin
					state <= wave_pkg::check_start;
				end else if (do_loop) begin
					cntr <= '0; // loop turned on late
					state <= wave_pkg::read_ram;
				end else begin
					finished <= 1'b1; // held until run drops
				end
			end
			wave_pkg::read_ram: begin
				cyc <= 1'b1;
				we <= 1'b0;
				state <= wave_pkg::wait_ram;
			end
			wave_pkg::wait_ram: if (ack) begin
				cyc <= 1'b0;
				state <= wave_pkg::write_data;
			end
			wave_pkg::write_data: begin
				cyc <= 1'b1;
				we <= 1'b1;
				state <= wave_pkg::wait_data;
			end
			wave_pkg::wait_data: if (ack) begin
				cyc <= 1'b0;
				state <= wave_pkg::write_arm;
			end
			wave_pkg::write_arm: begin
				cyc <= 1'b1;
				we <= 1'b1;
				state <= wave_pkg::wait_arm;
			end
			wave_pkg::wait_arm: if (ack) begin
				cyc <= 1'b0;
				state <= wave_pkg::write_disarm;
			end
			// disarm right away, the frame in flight keeps going
			wave_pkg::write_disarm: begin
				cyc <= 1'b1;
				we <= 1'b1;
				state <= wave_pkg::wait_disarm;
			end
			wave_pkg::wait_disarm: if (ack) begin
				cyc <= 1'b0;
				state <= wave_pkg::read_fin;
			end
			wave_pkg::read_fin: begin
				cyc <= 1'b1;
				we <= 1'b0;
				state <= wave_pkg::wait_fin;
			end
			wave_pkg::wait_fin: if (ack) begin // ack only once the shifter is idle
				cyc <= 1'b0;
				timer <= '0;
				state <= wave_pkg::wait_period;
			end
			wave_pkg::wait_period: begin
				if (!run) begin
					state <= wave_pkg::check_start; // graceful stop between frames
				end else if (timer < timer_spacing) begin
					timer <= timer + 1'b1;
				end else begin
					cntr <= cntr + 1'b1;
					state <= wave_pkg::check_len;
				end
			end
			default: state <= wave_pkg::check_start;
			endcase
		end
	end

	// address and write data, loaded in the issue states
	always_ff @(posedge clk) begin
		case (state)
		wave_pkg::read_ram: adr <= bus_pkg::ram_base + bus_pkg::adr_t'(cntr);
		wave_pkg::wait_ram: if (ack) begin
			// sample in the low bits plus the write command
			dat_w <= bus_pkg::dat_t'(wave_pkg::sample_t'(dat_r))
				| (bus_pkg::dat_t'(1) << wave_pkg::dac_write_cmd);
		end
		wave_pkg::write_data: adr <= bus_pkg::spi_base + bus_pkg::adr_t'(bus_pkg::reg_data);
		wave_pkg::write_arm: begin
			adr <= bus_pkg::spi_base + bus_pkg::adr_t'(bus_pkg::reg_arm);
			dat_w <= bus_pkg::dat_t'(1); // arm
		end
		wave_pkg::write_disarm: begin
			adr <= bus_pkg::spi_base + bus_pkg::adr_t'(bus_pkg::reg_arm);
			dat_w <= '0; // disarm
		end
		wave_pkg::read_fin: adr <= bus_pkg::spi_base + bus_pkg::adr_t'(bus_pkg::reg_fin);
		default: ;
		endcase
	end

endmodule

// File: rtl/waveform_top.sv
// host loads samples only while ready is high; load data is 20 bits per word
`timescale 1ns/1ps

module waveform_top (
	input logic clk,
	input logic rst_n,

	// playback control
	input logic run,
	input logic force_stop,
	input logic do_loop,
	input wave_pkg::cnt_t wform_size,
	input wave_pkg::timer_t timer_spacing,

	// host load port
	input logic load_we,
	input bus_pkg::ram_adr_t load_adr,
	input wave_pkg::sample_t load_dat,

	// status
	output logic ready,
	output logic finished,
	output wave_pkg::cnt_t cntr,

	// dac pins
	output logic sck,
	output logic mosi,
	output logic cs_n
);

	// master bus, we adr and dat_w go straight to the slaves
	logic bus_cyc;
	logic bus_stb;
	logic bus_we;
	bus_pkg::adr_t bus_adr;
	bus_pkg::dat_t bus_dat_w;
	bus_pkg::dat_t bus_dat_r;
	logic bus_ack;

	// decoded slave side
	logic ram_cyc;
	logic ram_ack;
	bus_pkg::dat_t ram_dat_r;
	logic spi_cyc;
	logic spi_ack;
	bus_pkg::dat_t spi_dat_r;

	waveform_sequencer i_waveform_sequencer (
		.clk(clk), .rst_n(rst_n),
		.run(run), .force_stop(force_stop), .do_loop(do_loop),
		.wform_size(wform_size), .timer_spacing(timer_spacing),
		.cntr(cntr), .timer(), // timer only watched in simulation
		.ready(ready), .finished(finished),
		.cyc(bus_cyc), .stb(bus_stb), .we(bus_we), .adr(bus_adr),
		.dat_w(bus_dat_w), .dat_r(bus_dat_r), .ack(bus_ack)
	);

	bus_decoder i_bus_decoder (
		.clk(clk), .rst_n(rst_n),
		.cyc(bus_cyc), .stb(bus_stb), .adr(bus_adr),
		.dat_r(bus_dat_r), .ack(bus_ack),
		.ram_cyc(ram_cyc), .ram_ack(ram_ack), .ram_dat_r(ram_dat_r),
		.spi_cyc(spi_cyc), .spi_ack(spi_ack), .spi_dat_r(spi_dat_r)
	);

	sample_ram i_sample_ram (
		.clk(clk), .rst_n(rst_n),
		.cyc(ram_cyc), .we(bus_we), .adr(bus_adr[bus_pkg::ram_adr_w-1:0]), // word index
		.dat_w(bus_dat_w), .dat_r(ram_dat_r), .ack(ram_ack),
		.load_we(load_we), .load_adr(load_adr), .load_dat(load_dat)
	);

	dac_spi_port i_dac_spi_port (
		.clk(clk), .rst_n(rst_n),
		.cyc(spi_cyc), .we(bus_we), .reg_sel(bus_adr[4:0]), // byte offset
		.dat_w(bus_dat_w), .dat_r(spi_dat_r), .ack(spi_ack),
		.sck(sck), .mosi(mosi), .cs_n(cs_n)
	);

endmodule

// File: tests/tb_waveform.sv
// random playback checks on waveform_top with xorshift samples and 16 ram words loaded per run
`timescale 1ns/1ps

module tb_waveform;

	localparam int frame_clks = wave_pkg::frame_w * 2 * wave_pkg::sck_half; // cs_n low span
	localparam int sel_ready = 0;
	localparam int sel_finished = 1;
	localparam int sel_cs_n = 2;

	logic clk;
	logic rst_n;
	logic run;
	logic force_stop;
	logic do_loop;
	wave_pkg::cnt_t wform_size;
	wave_pkg::timer_t timer_spacing;
	logic load_we;
	bus_pkg::ram_adr_t load_adr;
	wave_pkg::sample_t load_dat;
	logic ready;
	logic finished;
	wave_pkg::cnt_t cntr;
	logic sck;
	logic mosi;
	logic cs_n;

	logic [31:0] rng; // xorshift state
	wave_pkg::sample_t model [16]; // expected sample per ram word
	int cur_size;
	int errors = 0;
	int tests_ok = 0;
	int tests_bad = 0;

	// frame capture state updated on the falling clk edge only
	logic sck_q = 1'b0;
	logic cs_q = 1'b1;
	int cycle = 0;
	int nbits = 0;
	int falls = 0; // cs_n falls since reset
	int frames_done = 0;
	int start_cyc = 0;
	wave_pkg::frame_t shift = '0;
	wave_pkg::frame_t frame_q [$];
	int start_q [$];

	waveform_top i_waveform_top (
		.clk(clk), .rst_n(rst_n),
		.run(run), .force_stop(force_stop), .do_loop(do_loop),
		.wform_size(wform_size), .timer_spacing(timer_spacing),
		.load_we(load_we), .load_adr(load_adr), .load_dat(load_dat),
		.ready(ready), .finished(finished), .cntr(cntr),
		.sck(sck), .mosi(mosi), .cs_n(cs_n)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// mode 0 capture of mosi at each sck rise while cs_n is low
	always @(negedge clk) begin
		cycle = cycle + 1;
		if (rst_n) begin
			if (cs_q && !cs_n) begin // frame opens
				falls = falls + 1;
				nbits = 0;
				start_cyc = cycle;
			end
			if (!cs_n && sck && !sck_q) begin
				shift = {shift[wave_pkg::frame_w-2:0], mosi}; // msb first
				nbits = nbits + 1;
			end
			if (!cs_q && cs_n) begin // frame closes
				assert (nbits == wave_pkg::frame_w) else begin
					$display("frame cut short after %0d bits", nbits);
					errors = errors + 1;
				end
				frame_q.push_back(shift);
				start_q.push_back(start_cyc);
				frames_done = frames_done + 1;
			end
		end
		sck_q = sck;
		cs_q = cs_n;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// uniform-ish pick in lo..hi that advances the stream
	function automatic int pick(input int lo, input int hi);
		rng = xorshift(rng);
		return lo + int'(rng % (hi - lo + 1));
	endfunction

	// poll one status pin until it reaches level
	task automatic wait_level(input int which, input logic level, input int limit,
		input string what);
		int n;
		logic v;
		n = 0;
		v = ~level;
		while (v !== level && n < limit) begin
			@(posedge clk);
			n++;
			case (which)
			sel_ready: v = ready;
			sel_finished: v = finished;
			default: v = cs_n;
			endcase
		end
		assert (v === level) else begin
			$display("timeout waiting for %s", what);
			errors++;
		end
	endtask

	task automatic wait_frames(input int total, input int limit);
		int n;
		n = 0;
		while (frames_done < total && n < limit) begin
			@(posedge clk);
			n++;
		end
		assert (frames_done >= total) else begin
			$display("timeout waiting for frame %0d", total);
			errors++;
		end
	endtask

	// fill 16 words while ready is high
	task automatic load_samples();
		assert (ready) else begin
			$display("ERR ready exp 1 got %h", ready);
			errors++;
		end
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			rng = xorshift(rng);
			model[i] = rng[wave_pkg::sample_w-1:0];
			load_we <= 1'b1;
			load_adr <= bus_pkg::ram_adr_t'(i);
			load_dat <= rng[wave_pkg::sample_w-1:0];
		end
		@(posedge clk);
		load_we <= 1'b0;
	endtask

	// pop n frames and check data against sample | write bit and the start gaps
	task automatic check_frames(input int first, input int n, input int spacing);
		wave_pkg::frame_t exp;
		wave_pkg::frame_t got;
		int t;
		int prev;
		prev = -1;
		assert (frame_q.size() >= n) else begin
			$display("only %0d of %0d frames captured", frame_q.size(), n);
			errors++;
		end
		for (int k = 0; k < n && frame_q.size() > 0; k++) begin
			exp = wave_pkg::frame_t'(model[(first + k) % cur_size]);
			exp[wave_pkg::dac_write_cmd] = 1'b1;
			got = frame_q.pop_front();
			t = start_q.pop_front();
			assert (got == exp) else begin
				$display("ERR mosi exp %06h got %06h", exp, got);
				errors++;
			end
			if (prev >= 0) begin
				assert (t - prev >= frame_clks + spacing + 1) else begin
					$display("frame %0d started only %0d cycles after the one before",
						k, t - prev);
					errors++;
				end
			end
			prev = t;
		end
	endtask

	// graceful stop that lets the last frame drain
	task automatic stop_play(output int at_drop);
		@(posedge clk);
		run <= 1'b0;
		at_drop = frames_done;
		wait_level(sel_ready, 1'b1, 400, "ready after run drop");
		wait_level(sel_cs_n, 1'b1, 200, "cs_n idle");
		repeat (4) @(posedge clk);
	endtask

	task automatic end_test(input string name, input int err0);
		if (errors == err0) begin
			$display("%s passed", name);
			tests_ok++;
		end else begin
			$display("%s failed with %0d errors", name, errors - err0);
			tests_bad++;
		end
	endtask

	// one pass without loop and 200 quiet cycles after it
	task automatic play_once(input string name, input int size, input int spacing);
		int e0;
		int f0;
		int dummy;
		e0 = errors;
		cur_size = size;
		load_samples();
		@(posedge clk);
		wform_size <= wave_pkg::cnt_t'(size);
		timer_spacing <= wave_pkg::timer_t'(spacing);
		do_loop <= 1'b0;
		run <= 1'b1;
		wait_level(sel_ready, 1'b0, 2, "ready low after run");
		assert (cntr == '0) else begin
			$display("ERR cntr exp 0000 got %04h", cntr);
			errors++;
		end
		wait_level(sel_finished, 1'b1, size * 400 + 100, "finished");
		f0 = falls;
		repeat (200) @(posedge clk);
		assert (falls == f0) else begin
			$display("cs_n fell again after finished");
			errors++;
		end
		assert (finished) else begin
			$display("ERR finished exp 1 got %h", finished);
			errors++;
		end
		check_frames(0, size, spacing);
		assert (frame_q.size() == 0) else begin
			$display("%0d extra frames after the pass", frame_q.size());
			errors++;
		end
		stop_play(dummy);
		end_test(name, e0);
	endtask

	initial begin
		int e0;
		int spacing;
		int base;
		int at_drop;
		rng = 32'hcfc0_c9b3;
		rst_n = 1'b0;
		run = 1'b0;
		force_stop = 1'b0;
		do_loop = 1'b0;
		wform_size = '0;
		timer_spacing = '0;
		load_we = 1'b0;
		load_adr = '0;
		load_dat = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		wait_level(sel_ready, 1'b1, 20, "ready after reset");

		play_once("single_pass", pick(1, 12), pick(0, 7));
		play_once("spacing", pick(2, 12), pick(16, 40)); // wider gaps

		// loop for two and a half passes before a graceful stop
		e0 = errors;
		base = frames_done;
		load_samples();
		cur_size = pick(1, 12);
		spacing = pick(0, 7);
		@(posedge clk);
		wform_size <= wave_pkg::cnt_t'(cur_size);
		timer_spacing <= wave_pkg::timer_t'(spacing);
		do_loop <= 1'b1;
		run <= 1'b1;
		wait_frames(base + (cur_size * 5 + 1) / 2, cur_size * 1000 + 200);
		stop_play(at_drop);
		assert (frames_done - at_drop <= 1) else begin
			$display("%0d frames completed after run dropped", frames_done - at_drop);
			errors++;
		end
		check_frames(0, frames_done - base, spacing); // indices wrap through the model
		end_test("loop", e0);

		// force_stop in the middle of a frame
		e0 = errors;
		base = frames_done;
		load_samples();
		cur_size = pick(2, 12);
		spacing = pick(0, 7);
		@(posedge clk);
		wform_size <= wave_pkg::cnt_t'(cur_size);
		timer_spacing <= wave_pkg::timer_t'(spacing);
		do_loop <= 1'b1;
		run <= 1'b1;
		wait_frames(base + pick(1, 4), 2000);
		wait_level(sel_cs_n, 1'b0, 400, "cs_n low");
		repeat (pick(1, 60)) @(posedge clk); // land inside the frame
		force_stop <= 1'b1;
		run <= 1'b0;
		@(posedge clk);
		force_stop <= 1'b0;
		wait_level(sel_ready, 1'b1, 4, "ready after force_stop");
		wait_level(sel_cs_n, 1'b1, 200, "cs_n idle after force_stop");
		repeat (4) @(posedge clk);
		check_frames(0, frames_done - base, spacing);
		end_test("force_stop", e0);

		// new data after a stop and the counter starting over
		play_once("restart_reload", pick(1, 12), pick(0, 7));

		$display("tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
